// File: include/bp_config.svh
/*
 Sizing of the branch direction predictor.
 BP_QUEUE_DEPTH must be a power of two.
 The table has 2**(BP_PC_INDEX_BITS + BP_HIST_BITS) counters.
 Address bits for the index start at bit 2, so BP_PC_INDEX_BITS + 2
 must not exceed BP_PC_WIDTH.
*/
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// ====================
// address and slots
// ====================
// instruction address width
`define BP_PC_WIDTH 32
// fetch slots looked up per cycle
`define BP_LOOKUPS 4
// retire slots per cycle
`define BP_COMMITS 4

// ====================
// table and queue
// ====================
// global history bits joined into the index
`define BP_HIST_BITS 2
// address bits in the index, from bit 2 upward
`define BP_PC_INDEX_BITS 7
// outcome queue entries
`define BP_QUEUE_DEPTH 32

`endif

// File: hdl/bpPkg.sv
/*
 Types shared by the predictor RTL and its testbench.
 Index layout is {address bits, history}, history in the low bits.
*/
`default_nettype none

`include "bp_config.svh"

package bpPkg;

	// instruction address
	typedef logic [`BP_PC_WIDTH-1:0] pcT;

	// 2-bit saturating counter, 0 strongly not-taken, 3 strongly taken
	typedef logic [1:0] counterT;

	// pattern table index
	typedef logic [`BP_PC_INDEX_BITS+`BP_HIST_BITS-1:0] bhtIndexT;

	// one retired branch
	typedef struct packed {
		pcT   pc;
		logic taken;
	} outcomeT;

	// address bits above the word offset, history in the low bits
	function automatic bhtIndexT makeIndex(pcT pc, logic [`BP_HIST_BITS-1:0] hist);
		return {pc[`BP_PC_INDEX_BITS+1:2], hist};
	endfunction

endpackage

`default_nettype wire

// File: hdl/commitCompactor.sv
/*
 Registers the retire slots and packs the valid ones into a dense list.
 Lowest valid slot lands in entry 0. Entries at or above packedCount
 hold zero and carry no meaning.
 One cycle of latency, no back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module commitCompactor import bpPkg::*; (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic [`BP_COMMITS-1:0] commitValid,
	input  wire pcT                     commitPc [`BP_COMMITS],
	input  wire logic [`BP_COMMITS-1:0] commitTaken,
	output outcomeT                     packedOutcome [`BP_COMMITS],
	output logic [2:0]                  packedCount
);

	outcomeT    nextOutcome [`BP_COMMITS];
	logic [2:0] nextCount;

	// ====================
	// priority packing
	// ====================
	// each valid slot takes the next free entry
	always_comb begin
		nextCount = 3'd0;
		for (int i = 0; i < `BP_COMMITS; i++) begin
			nextOutcome[i] = '0;
		end
		for (int i = 0; i < `BP_COMMITS; i++) begin
			if (commitValid[i]) begin
				// count is at most i here, so the entry is in range
				nextOutcome[nextCount[1:0]] = '{pc: commitPc[i], taken: commitTaken[i]};
				nextCount = nextCount + 3'd1;
			end
		end
	end

	// ====================
	// output register
	// ====================
	// count is control, cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			packedCount <= 3'd0;
		end else begin
			packedCount <= nextCount;
		end
	end

	// payload follows the count every edge
	always_ff @(posedge clk) begin
		packedOutcome <= nextOutcome;
	end

endmodule

`default_nettype wire

// File: hdl/outcomeQueue.sv
/*
 Rate converter between retire and the table update.
 Takes up to BP_COMMITS outcomes per edge and releases one per pop.
 A group is taken whole or dropped whole. Free space is judged before
 the pop of the same edge, so a group that only fits after it is dropped.
 queueDrop pulses for one cycle after the dropping edge.
*/
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module outcomeQueue import bpPkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire outcomeT    packedOutcome [`BP_COMMITS],
	input  wire logic [2:0] packedCount,
	input  wire logic       pop,
	output outcomeT         headOutcome,
	output logic            notEmpty,
	output logic            queueDrop
);

	localparam int AW = $clog2(`BP_QUEUE_DEPTH);
	localparam logic [AW:0] DEPTH = (AW+1)'(`BP_QUEUE_DEPTH);

	outcomeT     mem [`BP_QUEUE_DEPTH];
	// one extra bit tells full from empty
	logic [AW:0] head;
	logic [AW:0] tail;
	logic [AW:0] used;
	logic [AW:0] free;
	logic [AW:0] pushCount;
	logic        accept;
	logic        drop;

	// ====================
	// occupancy
	// ====================
	assign used      = tail - head;
	assign free      = DEPTH - used;
	assign pushCount = (AW+1)'(packedCount);
	assign accept    = (packedCount != 3'd0) && (pushCount <= free);
	assign drop      = (packedCount != 3'd0) && (pushCount > free);

	assign notEmpty    = (head != tail);
	assign headOutcome = mem[head[AW-1:0]];

	// pointers and drop flag
	always_ff @(posedge clk) begin
		if (rst) begin
			head      <= '0;
			tail      <= '0;
			queueDrop <= 1'b0;
		end else begin
			queueDrop <= drop;
			if (accept) begin
				tail <= tail + pushCount;
			end
			if (pop) begin
				head <= head + (AW+1)'(1);
			end
		end
	end

	// storage, entries land in list order from the tail
	always_ff @(posedge clk) begin
		if (accept) begin
			for (int i = 0; i < `BP_COMMITS; i++) begin
				if (3'(i) < packedCount) begin
					mem[tail[AW-1:0] + AW'(i)] <= packedOutcome[i];
				end
			end
		end
	end

	// ====================
	// checks
	// ====================
	// the updater must only pop a present entry
	popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty);
	// pointers never run more than a full buffer apart
	noOverfill: assert property (@(posedge clk) disable iff (rst) used <= DEPTH);

endmodule

`default_nettype wire

// File: hdl/historyUpdater.sv
/*
 Pops one outcome per cycle while en is high and notEmpty.
 The popped outcome is written to the table in the following cycle,
 and the history shifts in its taken bit on that same edge.
 A held outcome is still written when en drops, only popping stalls.
*/
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module historyUpdater import bpPkg::*; (
	input  wire logic                     clk,
	input  wire logic                     rst,
	input  wire logic                     en,
	input  wire outcomeT                  headOutcome,
	input  wire logic                     notEmpty,
	output logic                          pop,
	output bhtIndexT                      updateIndex,
	input  wire counterT                  updateCounter,
	output logic                          writeEnable,
	output bhtIndexT                      writeIndex,
	output counterT                       writeCounter,
	output logic [`BP_HIST_BITS-1:0]      history
);

	outcomeT held;
	logic    holdValid;

	// ====================
	// pop stage
	// ====================
	assign pop = notEmpty && en;

	always_ff @(posedge clk) begin
		if (rst) begin
			holdValid <= 1'b0;
		end else begin
			holdValid <= pop;
		end
	end

	// payload register, meaningful only with holdValid
	always_ff @(posedge clk) begin
		if (pop) begin
			held <= headOutcome;
		end
	end

	// ====================
	// write stage
	// ====================
	// index uses the history before this outcome shifts in
	assign updateIndex = makeIndex(held.pc, history);
	assign writeIndex  = updateIndex;
	assign writeEnable = holdValid;

	// saturating step toward 3 on taken, toward 0 otherwise
	always_comb begin
		if (held.taken) begin
			writeCounter = (updateCounter == 2'd3) ? 2'd3 : updateCounter + 2'd1;
		end else begin
			writeCounter = (updateCounter == 2'd0) ? 2'd0 : updateCounter - 2'd1;
		end
	end

	// newest outcome in bit 0
	always_ff @(posedge clk) begin
		if (rst) begin
			history <= '0;
		end else if (holdValid) begin
			history <= {history[`BP_HIST_BITS-2:0], held.taken};
		end
	end

	// a popped entry was filled by an earlier push
	knownHead: assert property (@(posedge clk) disable iff (rst)
		pop |-> !$isunknown(headOutcome));

endmodule

`default_nettype wire

// File: hdl/patternTable.sv
/*
 Table of 2-bit counters, all set to 1 (weakly not-taken) on reset.
 Lookups and the update read are combinational.
 One write per edge, visible to lookups in the next cycle.
 Predictions are forced to not-taken while en is low.
*/
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module patternTable import bpPkg::*; (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    en,
	input  wire pcT                      lookupPc [`BP_LOOKUPS],
	input  wire logic [`BP_HIST_BITS-1:0] history,
	output logic [`BP_LOOKUPS-1:0]       predictTaken,
	input  wire bhtIndexT                updateIndex,
	output counterT                      updateCounter,
	input  wire logic                    writeEnable,
	input  wire bhtIndexT                writeIndex,
	input  wire counterT                 writeCounter
);

	localparam int ENTRIES = 2 ** $bits(bhtIndexT);

	counterT counters [ENTRIES];

	// ====================
	// storage
	// ====================
	// reset walks the whole table to weakly not-taken
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < ENTRIES; i++) begin
				counters[i] <= 2'd1;
			end
		end else if (writeEnable) begin
			counters[writeIndex] <= writeCounter;
		end
	end

	// ====================
	// read ports
	// ====================
	// counter upper bit is set for 2 and 3
	always_comb begin
		for (int i = 0; i < `BP_LOOKUPS; i++) begin
			predictTaken[i] = en && counters[makeIndex(lookupPc[i], history)][1];
		end
	end

	// dedicated port for the read-modify-write of the updater
	assign updateCounter = counters[updateIndex];

endmodule

`default_nettype wire

// File: hdl/branchPredictor.sv
/*
 Direction predictor top level.
 Lookups are combinational against the current table and history.
 Commits pass compactor, queue, updater, table; no back-pressure,
 a group that does not fit in the queue is dropped and queueDrop pulses.
*/
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module branchPredictor import bpPkg::*; (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   en,
	input  wire pcT                     lookupPc [`BP_LOOKUPS],
	input  wire logic [`BP_COMMITS-1:0] commitValid,
	input  wire pcT                     commitPc [`BP_COMMITS],
	input  wire logic [`BP_COMMITS-1:0] commitTaken,
	output logic [`BP_LOOKUPS-1:0]      predictTaken,
	output logic                        queueDrop
);

	// compactor to queue
	outcomeT                  packedOutcome [`BP_COMMITS];
	logic [2:0]               packedCount;
	// queue to updater
	outcomeT                  headOutcome;
	logic                     notEmpty;
	logic                     pop;
	// updater to table
	bhtIndexT                 updateIndex;
	counterT                  updateCounter;
	logic                     writeEnable;
	bhtIndexT                 writeIndex;
	counterT                  writeCounter;
	logic [`BP_HIST_BITS-1:0] history;

	// ====================
	// update pipeline
	// ====================
	commitCompactor compactor (
		.clk(clk), .rst(rst),
		.commitValid(commitValid), .commitPc(commitPc), .commitTaken(commitTaken),
		.packedOutcome(packedOutcome), .packedCount(packedCount)
	);

	outcomeQueue queue (
		.clk(clk), .rst(rst),
		.packedOutcome(packedOutcome), .packedCount(packedCount), .pop(pop),
		.headOutcome(headOutcome), .notEmpty(notEmpty), .queueDrop(queueDrop)
	);

	historyUpdater updater (
		.clk(clk), .rst(rst), .en(en),
		.headOutcome(headOutcome), .notEmpty(notEmpty), .pop(pop),
		.updateIndex(updateIndex), .updateCounter(updateCounter),
		.writeEnable(writeEnable), .writeIndex(writeIndex), .writeCounter(writeCounter),
		.history(history)
	);

	// lookups and writes share the table
	patternTable table0 (
		.clk(clk), .rst(rst), .en(en),
		.lookupPc(lookupPc), .history(history), .predictTaken(predictTaken),
		.updateIndex(updateIndex), .updateCounter(updateCounter),
		.writeEnable(writeEnable), .writeIndex(writeIndex), .writeCounter(writeCounter)
	);

endmodule

`default_nettype wire

// File: test/bpTb.sv
/*
 Directed testbench for the branch direction predictor.
 A reference model keeps the counter table, the history and the queued outcomes.
 The model pops one outcome per cycle while en is high. Its occupancy is exact
 only with en low, so the overflow test runs with en low.
 The run stops at the first mismatch.
*/
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bpTb import bpPkg::*; ();

	localparam int DEPTH = `BP_QUEUE_DEPTH;
	localparam int ENTRIES = 1 << (`BP_PC_INDEX_BITS + `BP_HIST_BITS);
	localparam int IDLE_CYCLES = DEPTH + 8;
	// a test holds up to four drain phases plus its commits and lookups
	localparam int TEST_CYCLES = 4 * IDLE_CYCLES + 60;
	localparam int WATCHDOG_CYCLES = 10 + 6 * TEST_CYCLES + 200;

	logic                   clk;
	logic                   rst;
	logic                   en;
	pcT                     lookupPc [`BP_LOOKUPS];
	logic [`BP_COMMITS-1:0] commitValid;
	pcT                     commitPc [`BP_COMMITS];
	logic [`BP_COMMITS-1:0] commitTaken;
	logic [`BP_LOOKUPS-1:0] predictTaken;
	logic                   queueDrop;

	// reference model state
	counterT                  modelTable [ENTRIES];
	logic [`BP_HIST_BITS-1:0] modelHist;
	outcomeT                  pending [$];

	branchPredictor UUT (
		.clk(clk), .rst(rst), .en(en),
		.lookupPc(lookupPc),
		.commitValid(commitValid), .commitPc(commitPc), .commitTaken(commitTaken),
		.predictTaken(predictTaken), .queueDrop(queueDrop)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ====================
	// reference model
	// ====================
	// word address field scaled above the history field
	function automatic bhtIndexT refIndex(pcT pc, logic [`BP_HIST_BITS-1:0] hist);
		int unsigned pcField;
		pcField = (pc >> 2) % (1 << `BP_PC_INDEX_BITS);
		return bhtIndexT'(pcField * (1 << `BP_HIST_BITS) + hist);
	endfunction

	// saturating step, then newest outcome into the low history bit
	function automatic void applyOutcome(outcomeT o);
		bhtIndexT idx;
		idx = refIndex(o.pc, modelHist);
		if (o.taken && modelTable[idx] != 2'd3) begin
			modelTable[idx] = modelTable[idx] + 2'd1;
		end else if (!o.taken && modelTable[idx] != 2'd0) begin
			modelTable[idx] = modelTable[idx] - 2'd1;
		end
		modelHist = (modelHist << 1) | `BP_HIST_BITS'(o.taken);
	endfunction

	function automatic logic modelPredict(pcT pc);
		return en && (modelTable[refIndex(pc, modelHist)] >= 2'd2);
	endfunction

	// ====================
	// drivers and checks
	// ====================
	// one clock edge, model drains one entry while enabled
	task automatic step();
		@(posedge clk);
		if (en && pending.size() != 0) begin
			applyOutcome(pending.pop_front());
		end
	endtask

	task automatic idle(int cycles);
		repeat (cycles) step();
	endtask

	task automatic setEnable(logic value);
		step();
		en <= value;
	endtask

	task automatic checkPrediction(string testName, logic [`BP_LOOKUPS-1:0] expected,
			logic [`BP_LOOKUPS-1:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s: expected %b, actual %b", testName, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "prediction check failed");
		end
	endtask

	task automatic checkDrop(string testName, logic expected, logic actual);
		if (expected !== actual) begin
			$display("MISMATCH %s: expected queueDrop %b, actual %b", testName, expected,
				actual);
			$display("TEST FAILED");
			$fatal(1, "drop check failed");
		end
	endtask

	// drive one commit group for one cycle and check the drop flag it causes
	task automatic sendGroup(string testName, logic [3:0] valid, pcT p0, pcT p1, pcT p2,
			pcT p3, logic [3:0] taken);
		pcT   pcs [`BP_COMMITS];
		int   count;
		logic expectDrop;
		pcs[0] = p0;
		pcs[1] = p1;
		pcs[2] = p2;
		pcs[3] = p3;
		count = $countones(valid);
		// group fits whole or is lost whole
		expectDrop = (count != 0) && (pending.size() + count > DEPTH);
		if (!expectDrop) begin
			for (int i = 0; i < `BP_COMMITS; i++) begin
				if (valid[i]) begin
					pending.push_back('{pc: pcs[i], taken: taken[i]});
				end
			end
		end
		step();
		for (int i = 0; i < `BP_COMMITS; i++) begin
			commitPc[i] <= pcs[i];
		end
		commitValid <= valid;
		commitTaken <= taken;
		// compactor samples here
		step();
		commitValid <= '0;
		// queue decides here, drop flag shows until the next edge
		step();
		@(negedge clk);
		checkDrop(testName, expectDrop, queueDrop);
	endtask

	// lookups settle combinationally, sampled mid cycle
	task automatic checkLookups(string testName, pcT p0, pcT p1, pcT p2, pcT p3);
		logic [`BP_LOOKUPS-1:0] expected;
		step();
		lookupPc[0] <= p0;
		lookupPc[1] <= p1;
		lookupPc[2] <= p2;
		lookupPc[3] <= p3;
		@(negedge clk);
		expected = {modelPredict(p3), modelPredict(p2), modelPredict(p1), modelPredict(p0)};
		checkPrediction(testName, expected, predictTaken);
	endtask

	// ====================
	// tests
	// ====================
	task automatic resetState();
		repeat (8) checkLookups("resetState", $urandom, $urandom, $urandom, $urandom);
	endtask

	// helper branch twice to reach history 11, then the branch twice under it
	task automatic twoTaken();
		sendGroup("twoTaken", 4'b1111, 32'h0000_1000, 32'h0000_1000, 32'h0000_2040,
			32'h0000_2040, 4'b1111);
		idle(IDLE_CYCLES);
		// alias above the index field, and a neighbour word
		checkLookups("twoTaken", 32'h0000_2040, 32'h0000_2240, 32'h0000_2044, 32'h0000_1000);
	endtask

	// slot 1 is invalid but carries a taken bit
	task automatic slotOrder();
		sendGroup("slotOrder", 4'b1101, 32'h1000_0080, 32'h0000_3300, 32'h9000_0080,
			32'h0000_04c0, 4'b1011);
		// helper branch twice brings the history back to 11 for the lookups
		sendGroup("slotOrder", 4'b0011, 32'h0000_1000, 32'h0000_1000, '0, '0, 4'b0011);
		idle(IDLE_CYCLES);
		checkLookups("slotOrder", 32'h1000_0080, 32'h9000_0080, 32'h0000_04c0, 32'h0000_3300);
	endtask

	task automatic saturation();
		sendGroup("saturation", 4'b1111, 32'h0000_0a40, 32'h0000_0a40, 32'h0000_0a40,
			32'h0000_0a40, 4'b1111);
		sendGroup("saturation", 4'b0001, 32'h0000_0a40, '0, '0, '0, 4'b0001);
		// one not-taken, then a helper branch twice to bring the history back
		sendGroup("saturation", 4'b0111, 32'h0000_0a40, 32'h0000_0d00, 32'h0000_0d00, '0,
			4'b0110);
		idle(IDLE_CYCLES);
		checkLookups("saturation", 32'h0000_0a40, 32'h0000_0d00, 32'h0000_0a44, 32'h0000_0000);
		sendGroup("saturation", 4'b1111, 32'h0000_0a40, 32'h0000_0a40, 32'h0000_0a40,
			32'h0000_0a40, 4'b0000);
		sendGroup("saturation", 4'b1111, 32'h0000_0a40, 32'h0000_0a40, 32'h0000_0a40,
			32'h0000_0a40, 4'b0000);
		idle(IDLE_CYCLES);
		checkLookups("saturation", 32'h0000_0a40, 32'h0000_0d00, 32'h0000_2040, 32'h0000_1000);
	endtask

	task automatic enableGate();
		setEnable(1'b0);
		sendGroup("enableGate", 4'b1111, 32'h0000_0e80, 32'h0000_0e80, 32'h0000_0e80,
			32'h0000_0e80, 4'b1111);
		idle(IDLE_CYCLES);
		// forced low, including branches trained taken before
		checkLookups("enableGate", 32'h0000_0e80, 32'h0000_2040, 32'h0000_0d00, 32'h1000_0080);
		setEnable(1'b1);
		idle(IDLE_CYCLES);
		checkLookups("enableGate", 32'h0000_0e80, 32'h0000_2040, 32'h0000_0d00, 32'h1000_0080);
	endtask

	// eight full groups fill the stalled queue, the ninth is dropped
	task automatic overflow();
		setEnable(1'b0);
		for (int g = 0; g < DEPTH / `BP_COMMITS; g++) begin
			sendGroup("overflow", 4'b1111, $urandom, $urandom, $urandom, $urandom,
				4'($urandom));
		end
		sendGroup("overflow", 4'b1111, 32'h0000_f000, 32'h0000_f100, 32'h0000_f200,
			32'h0000_f300, 4'b1111);
		setEnable(1'b1);
		idle(IDLE_CYCLES);
		checkLookups("overflow", 32'h0000_f000, 32'h0000_f100, 32'h0000_f200, 32'h0000_f300);
	endtask

	// ====================
	// sequence
	// ====================
	initial begin
		void'($urandom(32'h10e7));
		rst = 1'b1;
		en = 1'b1;
		commitValid = '0;
		commitTaken = '0;
		for (int i = 0; i < `BP_COMMITS; i++) begin
			commitPc[i] = '0;
		end
		for (int i = 0; i < `BP_LOOKUPS; i++) begin
			lookupPc[i] = '0;
		end
		for (int i = 0; i < ENTRIES; i++) begin
			modelTable[i] = 2'd1;
		end
		modelHist = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		resetState();
		twoTaken();
		slotOrder();
		saturation();
		enableGate();
		overflow();
		$display("TEST PASSED");
		$finish;
	end

	// watchdog sized from the per-test budget
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
hdl/bpPkg.sv
hdl/commitCompactor.sv
hdl/outcomeQueue.sv
hdl/historyUpdater.sv
hdl/patternTable.sv
hdl/branchPredictor.sv
test/bpTb.sv

// File: Makefile
# Verilator flow for the branch predictor testbench
VERILATOR ?= verilator
TOP       ?= bpTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TEST PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
sim: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
